// ==== Makefile ====
SRCS := $(shell cat tb.f)

obj_dir/Vtb_soc: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_soc -f tb.f

run: obj_dir/Vtb_soc
	@out="$$(./obj_dir/Vtb_soc)"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== tb.f ====
verilog/soc_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/wb_intercon.sv
verilog/wb_ram.sv
verilog/wb_uart_tx.sv
verilog/soc_top.sv
test/soc_sva.sv
test/tb_soc.sv

// ==== test/soc_sva.sv ====
`timescale 1ns/1ps

module soc_sva (
	input logic wb_clk_i,
	input logic rst_n_i,
	input logic ack_i,
	input logic err_i,
	input logic tx_i,
	input logic busy_i
);

	logic resp;

	assign resp = ack_i | err_i;

	// One kind of answer per access
	a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		!(ack_i && err_i))
		else $error("ack and err high together");

	// Responses last a single cycle
	a_resp_single: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		resp |=> !resp)
		else $error("bus response held for two cycles");

	// Idle line stays high
	a_tx_idle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		!busy_i |-> tx_i)
		else $error("serial line low while transmitter idle");

endmodule

bind soc_top soc_sva sva0 (
	.wb_clk_i (wb_clk_i),
	.rst_n_i  (rst_n_i),
	.ack_i    (wb_ack_o),
	.err_i    (wb_err_o),
	.tx_i     (uart_tx_o),
	.busy_i   (uart0.busy_q)
);

// ==== test/tb_soc.sv ====
`timescale 1ns/1ps

module tb_soc;

	localparam int TIMEOUT = 2000;
	localparam logic [31:0] SEED = 32'hf333;
	localparam int RAM_WORDS = 2**soc_map_pkg::RAM_AW;

	logic                          wb_clk_i;
	logic                          rst_n_i;
	logic [soc_bus_pkg::WB_AW-1:0] wb_adr_i;
	logic [soc_bus_pkg::WB_DW-1:0] wb_dat_i;
	logic [soc_bus_pkg::WB_SW-1:0] wb_sel_i;
	logic                          wb_we_i;
	logic                          wb_cyc_i;
	logic                          wb_stb_i;
	logic [soc_bus_pkg::WB_DW-1:0] wb_dat_o;
	logic                          wb_ack_o;
	logic                          wb_err_o;
	logic                          uart_tx_o;
	logic                          irq_o;

	logic [31:0] lfsr;
	int          cycle = 0;
	int          errors = 0;
	int          checks = 0;
	logic [31:0] ram_model [0:RAM_WORDS-1];
	logic [9:0]  words [$];
	logic [3:0]  region;
	logic        ien_model;
	logic [15:0] div_model;
	logic [31:0] rdata;
	logic        got_ack;
	logic        got_err;

	soc_top DUT (.*);

	initial begin
		wb_clk_i = 1'b0;
		forever #2 wb_clk_i = ~wb_clk_i;
	end

	// Edge counter for serial bit timing
	always @(posedge wb_clk_i)
		cycle <= cycle + 1;

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			val = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic logic [31:0] ram_adr(input logic [9:0] word);
		logic [15:0] pad;
		pad = 16'(rand_bits(16));
		return {soc_map_pkg::REGION_RAM, pad, word, 2'b00};
	endfunction

	function automatic logic [31:0] uart_adr(input logic [1:0] idx);
		return {soc_map_pkg::REGION_UART, 24'h0, idx, 2'b00};
	endfunction

	// Start bit low, then data LSB first, then stop bit high
	function automatic logic frame_bit(input logic [7:0] data, input int k);
		if (k == 0)
			return 1'b0;
		else if (k == 9)
			return 1'b1;
		else
			return data[k-1];
	endfunction

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	task automatic timed_out(input string what);
		errors++;
		$display("Timeout while waiting for %s", what);
		finish_run();
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic expect_resp(input logic ack_exp, input logic err_exp);
		checks++;
		if (got_ack !== ack_exp || got_err !== err_exp) begin
			errors++;
			$display("Error: wb_ack_o/wb_err_o are %h/%h, expected %h/%h",
				got_ack, got_err, ack_exp, err_exp);
		end
	endtask

	////////////////////
	// Bus access
	////////////////////

	task automatic bus_access(input logic [31:0] adr, input logic we, input logic [31:0] dat,
			input logic [3:0] sel);
		int n;
		@(posedge wb_clk_i);
		wb_adr_i <= adr;
		wb_we_i  <= we;
		wb_dat_i <= dat;
		wb_sel_i <= sel;
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		n = 0;
		do begin
			@(posedge wb_clk_i);
			n++;
			if (n > TIMEOUT)
				timed_out("a bus response");
		end while (!(wb_ack_o | wb_err_o));
		rdata   = wb_dat_o;
		got_ack = wb_ack_o;
		got_err = wb_err_o;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
	endtask

	task automatic ram_write(input logic [9:0] word, input logic [31:0] dat,
			input logic [3:0] sel);
		bus_access(ram_adr(word), 1'b1, dat, sel);
		expect_resp(1'b1, 1'b0);
		for (int b = 0; b < 4; b++)
			if (sel[b])
				ram_model[word][b*8 +: 8] = dat[b*8 +: 8];
	endtask

	task automatic ram_check(input logic [9:0] word);
		bus_access(ram_adr(word), 1'b0, 32'h0, 4'hf);
		expect_resp(1'b1, 1'b0);
		expect_eq("wb_dat_o", rdata, ram_model[word]);
	endtask

	task automatic uart_write(input logic [1:0] idx, input logic [31:0] dat, input logic err_exp);
		bus_access(uart_adr(idx), 1'b1, dat, 4'hf);
		expect_resp(~err_exp, err_exp);
	endtask

	task automatic uart_check(input logic [1:0] idx, input logic [31:0] exp);
		bus_access(uart_adr(idx), 1'b0, 32'h0, 4'hf);
		expect_resp(1'b1, 1'b0);
		expect_eq("wb_dat_o", rdata, exp);
	endtask

	////////////////////
	// Serial monitor
	////////////////////

	task automatic wait_cycle(input int target);
		int n;
		n = 0;
		while (cycle < target) begin
			@(posedge wb_clk_i);
			n++;
			if (n > TIMEOUT)
				timed_out("a serial sample point");
		end
		if (cycle > target) begin
			errors++;
			$display("Missed the serial sample point at cycle %0d", target);
		end
	endtask

	// Each bit is sampled in its middle
	task automatic check_frame(input logic [7:0] data, input logic poke);
		int start;
		int d;
		d = int'(div_model);
		uart_write(soc_map_pkg::UART_REG_TXDATA, {24'h0, data}, 1'b0);
		// Accepting edge is one before the response edge
		start = cycle - 1;
		for (int k = 0; k < 10; k++) begin
			wait_cycle(start + k * (d + 1) + d / 2 + 1);
			expect_eq("uart_tx_o", 32'(uart_tx_o), 32'(frame_bit(data, k)));
			expect_eq("irq_o", 32'(irq_o), 32'h0);
			if (k == 4 || k == 9)
				uart_check(soc_map_pkg::UART_REG_STATUS, 32'h1);
			// Second byte while the frame is on the line
			if (k == 4 && poke)
				uart_write(soc_map_pkg::UART_REG_TXDATA, rand_bits(8), 1'b1);
		end
		wait_cycle(start + 10 * (d + 1) + 1);
		expect_eq("irq_o", 32'(irq_o), 32'(ien_model));
		uart_check(soc_map_pkg::UART_REG_STATUS, 32'h0);
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		lfsr = SEED;
		rst_n_i  <= 1'b0;
		wb_adr_i <= '0;
		wb_dat_i <= '0;
		wb_sel_i <= '0;
		wb_we_i  <= 1'b0;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		ien_model = 1'b0;
		div_model = soc_map_pkg::UART_DIV_RESET;
		repeat (2) @(posedge wb_clk_i);
		rst_n_i <= 1'b1;

		// Reset state of the UART block
		expect_eq("uart_tx_o", 32'(uart_tx_o), 32'h1);
		expect_eq("irq_o", 32'(irq_o), 32'h0);
		uart_check(soc_map_pkg::UART_REG_DIV, 32'(soc_map_pkg::UART_DIV_RESET));
		uart_check(soc_map_pkg::UART_REG_IEN, 32'h0);
		uart_check(soc_map_pkg::UART_REG_STATUS, 32'h0);
		uart_check(soc_map_pkg::UART_REG_TXDATA, 32'h0);
		uart_write(soc_map_pkg::UART_REG_STATUS, rand_bits(32), 1'b0);
		uart_check(soc_map_pkg::UART_REG_STATUS, 32'h0);

		// Full words first, then random byte lanes
		for (int i = 0; i < 16; i++) begin
			words.push_back(10'(rand_bits(10)));
			ram_write(words[i], rand_bits(32), 4'hf);
		end
		for (int i = 0; i < 48; i++)
			ram_write(words[rand_bits(4)], rand_bits(32), 4'(rand_bits(4)));
		foreach (words[i])
			ram_check(words[i]);

		// Unmapped regions answer with err and leave RAM alone
		for (int i = 0; i < 8; i++) begin
			region = 4'(rand_bits(4));
			while (region == soc_map_pkg::REGION_RAM || region == soc_map_pkg::REGION_UART)
				region = 4'(rand_bits(4));
			bus_access({region, 16'(rand_bits(16)), words[i], 2'b00}, 1'(rand_bits(1)),
				rand_bits(32), 4'hf);
			expect_resp(1'b0, 1'b1);
			ram_check(words[i]);
		end

		// Frames with IEN cleared, then set
		for (int i = 0; i < 4; i++) begin
			div_model = 16'(5 + rand_bits(3));
			uart_write(soc_map_pkg::UART_REG_DIV, {16'(rand_bits(16)), div_model}, 1'b0);
			ien_model = i[1];
			uart_write(soc_map_pkg::UART_REG_IEN, {31'(rand_bits(31)), ien_model}, 1'b0);
			uart_check(soc_map_pkg::UART_REG_DIV, 32'(div_model));
			uart_check(soc_map_pkg::UART_REG_IEN, 32'(ien_model));
			expect_eq("irq_o", 32'(irq_o), 32'(ien_model));
			check_frame(8'(rand_bits(8)), i[0]);
		end

		finish_run();
	end

endmodule

// ==== verilog/soc_bus_pkg.sv ====
package soc_bus_pkg;

	////////////////////
	// Wishbone widths
	////////////////////

	// Byte address, full 32-bit space
	localparam int WB_AW = 32;

	// Data bus, one word per access
	localparam int WB_DW = 32;

	// One select bit per byte lane
	localparam int WB_SW = 4;

	////////////////////
	// Byte lanes
	////////////////////

	// Bits per lane
	localparam int WB_BYTE_W = 8;

	// Low address bits that pick a byte inside a word
	localparam int WB_OFS_W = 2;

endpackage

// ==== verilog/soc_map_pkg.sv ====
package soc_map_pkg;

	////////////////////
	// Address map
	////////////////////

	// Top address nibble selects the slave
	localparam int REGION_W = 4;
	localparam logic [REGION_W-1:0] REGION_RAM  = 4'h0;
	localparam logic [REGION_W-1:0] REGION_UART = 4'h9;

	// Main RAM, 1024 words
	localparam int RAM_AW = 10;

	////////////////////
	// UART registers
	////////////////////

	localparam int UART_REG_W = 2;
	localparam logic [UART_REG_W-1:0] UART_REG_TXDATA = 2'd0;
	localparam logic [UART_REG_W-1:0] UART_REG_STATUS = 2'd1;
	localparam logic [UART_REG_W-1:0] UART_REG_DIV    = 2'd2;
	localparam logic [UART_REG_W-1:0] UART_REG_IEN    = 2'd3;

	localparam int UART_DIV_W = 16;
	localparam logic [UART_DIV_W-1:0] UART_DIV_RESET = 16'd3;

	// Start, eight data bits, stop
	localparam int UART_FRAME_BITS = 10;

	// Memory view of a bus address
	typedef struct packed {
		logic [REGION_W-1:0] region;
		logic [soc_bus_pkg::WB_AW-REGION_W-RAM_AW-soc_bus_pkg::WB_OFS_W-1:0] unused;
		logic [RAM_AW-1:0] word;
		logic [soc_bus_pkg::WB_OFS_W-1:0] byte_ofs;
	} mem_view_t;

	// Register view of the same address
	typedef struct packed {
		logic [REGION_W-1:0] region;
		logic [soc_bus_pkg::WB_AW-REGION_W-UART_REG_W-soc_bus_pkg::WB_OFS_W-1:0] unused;
		logic [UART_REG_W-1:0] idx;
		logic [soc_bus_pkg::WB_OFS_W-1:0] byte_ofs;
	} csr_view_t;

	typedef union packed {
		mem_view_t mem;
		csr_view_t csr;
	} soc_addr_u;

endpackage

// ==== verilog/soc_top.sv ====
`timescale 1ns/1ps

module soc_top (
	input  logic                          wb_clk_i,
	input  logic                          rst_n_i,
	input  logic [soc_bus_pkg::WB_AW-1:0] wb_adr_i,
	input  logic [soc_bus_pkg::WB_DW-1:0] wb_dat_i,
	input  logic [soc_bus_pkg::WB_SW-1:0] wb_sel_i,
	input  logic                          wb_we_i,
	input  logic                          wb_cyc_i,
	input  logic                          wb_stb_i,
	output logic [soc_bus_pkg::WB_DW-1:0] wb_dat_o,
	output logic                          wb_ack_o,
	output logic                          wb_err_o,
	output logic                          uart_tx_o,
	output logic                          irq_o
);

	logic                          ram_stb;
	logic [soc_bus_pkg::WB_DW-1:0] ram_dat;
	logic                          ram_ack;
	logic                          uart_stb;
	logic [soc_bus_pkg::WB_DW-1:0] uart_dat;
	logic                          uart_ack;
	logic                          uart_err;

	////////////////////
	// Interconnect
	////////////////////

	wb_intercon intercon0 (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.wb_adr_i   (wb_adr_i),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.ram_dat_i  (ram_dat),
		.ram_ack_i  (ram_ack),
		.uart_dat_i (uart_dat),
		.uart_ack_i (uart_ack),
		.uart_err_i (uart_err),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.wb_err_o   (wb_err_o),
		.ram_stb_o  (ram_stb),
		.uart_stb_o (uart_stb)
	);

	////////////////////
	// Slaves
	////////////////////

	// Address, data, sel and we fan out to both slaves
	wb_ram ram0 (
		.wb_clk_i  (wb_clk_i),
		.rst_n_i   (rst_n_i),
		.ram_stb_i (ram_stb),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_sel_i  (wb_sel_i),
		.ram_dat_o (ram_dat),
		.ram_ack_o (ram_ack)
	);

	wb_uart_tx uart0 (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.uart_stb_i (uart_stb),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.uart_dat_o (uart_dat),
		.uart_ack_o (uart_ack),
		.uart_err_o (uart_err),
		.uart_tx_o  (uart_tx_o),
		.irq_o      (irq_o)
	);

endmodule

// ==== verilog/wb_intercon.sv ====
`timescale 1ns/1ps

module wb_intercon (
	input  logic                          wb_clk_i,
	input  logic                          rst_n_i,
	input  logic [soc_bus_pkg::WB_AW-1:0] wb_adr_i,
	input  logic                          wb_cyc_i,
	input  logic                          wb_stb_i,
	input  logic [soc_bus_pkg::WB_DW-1:0] ram_dat_i,
	input  logic                          ram_ack_i,
	input  logic [soc_bus_pkg::WB_DW-1:0] uart_dat_i,
	input  logic                          uart_ack_i,
	input  logic                          uart_err_i,
	output logic [soc_bus_pkg::WB_DW-1:0] wb_dat_o,
	output logic                          wb_ack_o,
	output logic                          wb_err_o,
	output logic                          ram_stb_o,
	output logic                          uart_stb_o
);

	soc_map_pkg::soc_addr_u adr;
	logic [soc_map_pkg::REGION_W-1:0] region_q;
	logic req;
	logic hit_ram;
	logic hit_uart;
	logic unmapped;
	logic resp;
	logic miss_err_q;

	assign adr = wb_adr_i;
	assign req = wb_cyc_i & wb_stb_i;

	////////////////////
	// Address decode
	////////////////////

	assign hit_ram  = adr.mem.region == soc_map_pkg::REGION_RAM;
	assign hit_uart = adr.mem.region == soc_map_pkg::REGION_UART;
	assign unmapped = ~hit_ram & ~hit_uart;

	// At most one slave sees a strobe
	assign ram_stb_o  = req & hit_ram;
	assign uart_stb_o = req & hit_uart;

	// A response is on the bus this cycle
	assign resp = wb_ack_o | wb_err_o;

	// Latch region at access start; no update while the response is out
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			region_q   <= soc_map_pkg::REGION_RAM;
			miss_err_q <= 1'b0;
		end else begin
			if (req & ~resp)
				region_q <= adr.mem.region;
			miss_err_q <= req & ~resp & unmapped;
		end
	end

	////////////////////
	// Response mux
	////////////////////

	always_comb begin
		wb_dat_o = '0;
		wb_ack_o = 1'b0;
		wb_err_o = miss_err_q;
		case (region_q)
			soc_map_pkg::REGION_RAM: begin
				wb_dat_o = ram_dat_i;
				wb_ack_o = ram_ack_i;
			end
			soc_map_pkg::REGION_UART: begin
				wb_dat_o = uart_dat_i;
				wb_ack_o = uart_ack_i;
				wb_err_o = uart_err_i;
			end
			default: begin
				// Unmapped, only the local err flag answers
				wb_dat_o = '0;
			end
		endcase
	end

endmodule

// ==== verilog/wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram (
	input  logic                          wb_clk_i,
	input  logic                          rst_n_i,
	input  logic                          ram_stb_i,
	input  logic                          wb_we_i,
	input  logic [soc_bus_pkg::WB_AW-1:0] wb_adr_i,
	input  logic [soc_bus_pkg::WB_DW-1:0] wb_dat_i,
	input  logic [soc_bus_pkg::WB_SW-1:0] wb_sel_i,
	output logic [soc_bus_pkg::WB_DW-1:0] ram_dat_o,
	output logic                          ram_ack_o
);

	logic [soc_bus_pkg::WB_DW-1:0] mem [0:(2**soc_map_pkg::RAM_AW)-1];
	soc_map_pkg::soc_addr_u adr;
	logic access;

	assign adr = wb_adr_i;

	// Strobe during our own ack belongs to the finished access
	assign access = ram_stb_i & ~ram_ack_o;

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			ram_ack_o <= 1'b0;
		else
			ram_ack_o <= access;
	end

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			if (wb_we_i) begin
				for (int b = 0; b < soc_bus_pkg::WB_SW; b++) begin
					if (wb_sel_i[b])
						mem[adr.mem.word][b*soc_bus_pkg::WB_BYTE_W +: soc_bus_pkg::WB_BYTE_W] <=
							wb_dat_i[b*soc_bus_pkg::WB_BYTE_W +: soc_bus_pkg::WB_BYTE_W];
				end
			end else begin
				// Whole word, sel only matters on writes
				ram_dat_o <= mem[adr.mem.word];
			end
		end
	end

endmodule

// ==== verilog/wb_uart_tx.sv ====
`timescale 1ns/1ps

module wb_uart_tx (
	input  logic                          wb_clk_i,
	input  logic                          rst_n_i,
	input  logic                          uart_stb_i,
	input  logic                          wb_we_i,
	input  logic [soc_bus_pkg::WB_AW-1:0] wb_adr_i,
	input  logic [soc_bus_pkg::WB_DW-1:0] wb_dat_i,
	output logic [soc_bus_pkg::WB_DW-1:0] uart_dat_o,
	output logic                          uart_ack_o,
	output logic                          uart_err_o,
	output logic                          uart_tx_o,
	output logic                          irq_o
);

	soc_map_pkg::soc_addr_u adr;
	logic access;
	logic tx_write;
	logic refuse;
	logic [soc_bus_pkg::WB_DW-1:0] rd_val;
	logic [soc_map_pkg::UART_DIV_W-1:0] div_q;
	logic [soc_map_pkg::UART_DIV_W-1:0] div_cnt;
	logic [3:0] bit_cnt;
	logic [soc_map_pkg::UART_FRAME_BITS-1:0] shift_q;
	logic ien_q;
	logic busy_q;

	assign adr = wb_adr_i;
	assign access = uart_stb_i & ~uart_ack_o & ~uart_err_o;
	assign tx_write = access & wb_we_i & (adr.csr.idx == soc_map_pkg::UART_REG_TXDATA);

	// Frame in flight, new byte is turned away
	assign refuse = tx_write & busy_q;

	// Line idles high once the shifter has filled with ones
	assign uart_tx_o = shift_q[0];
	assign irq_o = ien_q & ~busy_q;

	////////////////////
	// Registers and serializer
	////////////////////

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			uart_ack_o <= 1'b0;
			uart_err_o <= 1'b0;
			div_q      <= soc_map_pkg::UART_DIV_RESET;
			ien_q      <= 1'b0;
			busy_q     <= 1'b0;
			div_cnt    <= '0;
			bit_cnt    <= '0;
			shift_q    <= '1;
		end else begin
			uart_ack_o <= access & ~refuse;
			uart_err_o <= refuse;

			// Bit timing, divisor+1 cycles per bit
			if (busy_q) begin
				if (div_cnt == div_q) begin
					div_cnt <= '0;
					shift_q <= {1'b1, shift_q[soc_map_pkg::UART_FRAME_BITS-1:1]};
					bit_cnt <= bit_cnt + 4'd1;
					if (bit_cnt == 4'(soc_map_pkg::UART_FRAME_BITS - 1))
						busy_q <= 1'b0;
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end

			if (access & wb_we_i) begin
				case (adr.csr.idx)
					soc_map_pkg::UART_REG_TXDATA: begin
						if (!busy_q) begin
							// Stop, data LSB first, start bit at the bottom
							shift_q <= {1'b1, wb_dat_i[7:0], 1'b0};
							busy_q  <= 1'b1;
							div_cnt <= '0;
							bit_cnt <= '0;
						end
					end
					soc_map_pkg::UART_REG_DIV:
						div_q <= wb_dat_i[soc_map_pkg::UART_DIV_W-1:0];
					soc_map_pkg::UART_REG_IEN:
						ien_q <= wb_dat_i[0];
					default: begin
						// STATUS is read-only
						ien_q <= ien_q;
					end
				endcase
			end
		end
	end

	////////////////////
	// Read path
	////////////////////

	always_comb begin
		rd_val = '0;
		case (adr.csr.idx)
			soc_map_pkg::UART_REG_STATUS: rd_val[0] = busy_q;
			soc_map_pkg::UART_REG_DIV:    rd_val[soc_map_pkg::UART_DIV_W-1:0] = div_q;
			soc_map_pkg::UART_REG_IEN:    rd_val[0] = ien_q;
			default:                      rd_val = '0;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (access & ~wb_we_i)
			uart_dat_o <= rd_val;
	end

endmodule
